// File: files.f
+incdir+.
usb_pkg.sv
hash_pkg.sv
pd_ifs.sv
pd_controller.sv
block_store.sv
block_hasher.sv
packet_decoder_top.sv
tb_packet_decoder.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_packet_decoder -f files.f -o tb_sim

./obj_dir/tb_sim 2>&1 | tee sim.log

if grep -q "SIMULATION FAILED" sim.log; then
	echo "run_sim: testbench reported a failure"
	exit 1
fi
echo "run_sim: no failure found in sim.log"

// File: tb_packet_decoder.sv
// ============================================================
// Packet decoder testbench: packet tasks, reference digest,
// pulse monitor, compare tasks and timeout
// ============================================================
`include "pd_params.svh"

module tb_packet_decoder import usb_pkg::*, hash_pkg::*;;

	localparam int P_ACK = 0;
	localparam int P_NACK = 1;
	localparam int P_HR = 2;
	localparam int P_INT = 3;
	localparam int P_PERR = 4;
	localparam int P_DV = 5;

	// Seven tokens, six DATA1 blocks, two DATA0 packets, one bad PID packet
	localparam int TOTAL_BYTES = 7 * 2 + 6 * (1 + `PD_BLOCK_BYTES) + 2 * 2 + 2;
	localparam int TIMEOUT_CYCLES = TOTAL_BYTES * 8 + 500;

	logic clk;
	logic n_rst;
	logic write_enable;
	rx_byte_t rx_data;
	logic eop;
	logic rcv_error;
	logic transmit_ack;
	logic transmit_nack;
	logic host_ready;
	logic interrupt;
	logic p_error;
	logic digest_valid;
	digest_t digest;

	int pulse_cnt [6];
	int base_cnt [6];
	int cycle_cnt = 0;
	logic [31:0] lcg_state;
	digest_t exp_q [$];
	digest_t last_ref;
	rx_byte_t blk_a [$];
	rx_byte_t blk_b [$];

	packet_decoder_top dut_i (
		.clk(clk),
		.n_rst(n_rst),
		.write_enable(write_enable),
		.rx_data(rx_data),
		.eop(eop),
		.rcv_error(rcv_error),
		.transmit_ack(transmit_ack),
		.transmit_nack(transmit_nack),
		.host_ready(host_ready),
		.interrupt(interrupt),
		.p_error(p_error),
		.digest_valid(digest_valid),
		.digest(digest)
	);

	always #10 clk = ~clk;

	function automatic logic [31:0] lcg_step(logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// Seed, then rotate left by 5 and xor each byte from index 0 up
	function automatic digest_t ref_digest(rx_byte_t bytes [$]);
		digest_t d;
		d = `PD_DIGEST_SEED;
		foreach (bytes[i]) begin
			d = (d << 5) | (d >> 27);
			d = d ^ 32'(bytes[i]);
		end
		return d;
	endfunction

	function automatic string pulse_label(int idx);
		case (idx)
			P_ACK: return "transmit_ack";
			P_NACK: return "transmit_nack";
			P_HR: return "host_ready";
			P_INT: return "interrupt";
			P_PERR: return "p_error";
			default: return "digest_valid";
		endcase
	endfunction

	task automatic abort_run(string msg);
		$display("%s", msg);
		$display("SIMULATION FAILED");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check_digest(digest_t got, digest_t exp);
		if (got !== exp) begin
			abort_run($sformatf("ERR digest got %h exp %h", got, exp));
		end
	endtask

	task automatic check_pulse(int idx, int exp);
		int got;
		got = pulse_cnt[idx] - base_cnt[idx];
		if (got != exp) begin
			abort_run($sformatf("ERR %s count got %h exp %h", pulse_label(idx), got, exp));
		end
	endtask

	task automatic check_counts(int ack, int nack, int hr, int intr, int perr, int dv);
		check_pulse(P_ACK, ack);
		check_pulse(P_NACK, nack);
		check_pulse(P_HR, hr);
		check_pulse(P_INT, intr);
		check_pulse(P_PERR, perr);
		check_pulse(P_DV, dv);
	endtask

	task automatic mark_counts();
		foreach (base_cnt[i]) begin
			base_cnt[i] = pulse_cnt[i];
		end
	endtask

	task automatic make_block(output rx_byte_t bytes [$]);
		bytes = {};
		repeat (`PD_BLOCK_BYTES) begin
			lcg_state = lcg_step(lcg_state);
			bytes.push_back(lcg_state[23:16]);
		end
	endtask

	// One strobe cycle, then one idle cycle
	task automatic send_byte(rx_byte_t b);
		@(posedge clk);
		write_enable <= 1'b1;
		rx_data <= b;
		@(posedge clk);
		write_enable <= 1'b0;
	endtask

	task automatic end_packet();
		@(posedge clk);
		eop <= 1'b1;
		@(posedge clk);
		@(posedge clk);
		eop <= 1'b0;
	endtask

	task automatic send_token(rx_byte_t pid, dev_addr_t addr);
		send_byte(pid);
		send_byte({1'b0, addr});
		end_packet();
		repeat (4) @(posedge clk);
	endtask

	// err_at below zero sends a clean payload
	task automatic send_data1(rx_byte_t bytes [$], int err_at);
		send_byte(PID_DATA1);
		foreach (bytes[i]) begin
			if (i == err_at) begin
				@(posedge clk);
				rcv_error <= 1'b1;
				@(posedge clk);
				rcv_error <= 1'b0;
			end
			send_byte(bytes[i]);
		end
		end_packet();
	endtask

	task automatic send_data0(rx_byte_t cmd);
		send_byte(PID_DATA0);
		send_byte(cmd);
		end_packet();
	endtask

	task automatic wait_pulse(int idx, int n);
		while (pulse_cnt[idx] - base_cnt[idx] < n) begin
			@(posedge clk);
		end
	endtask

	task automatic settle();
		repeat (4) @(posedge clk);
	endtask

	// Pulse counter and digest compare on the falling edge
	always @(negedge clk) begin
		if (n_rst) begin
			if (transmit_ack) pulse_cnt[P_ACK]++;
			if (transmit_nack) pulse_cnt[P_NACK]++;
			if (host_ready) pulse_cnt[P_HR]++;
			if (interrupt) pulse_cnt[P_INT]++;
			if (p_error) pulse_cnt[P_PERR]++;
			if (digest_valid) begin
				pulse_cnt[P_DV]++;
				if (exp_q.size() == 0) begin
					abort_run("digest_valid pulsed with no full block sent");
				end else begin
					check_digest(digest, exp_q.pop_front());
				end
			end
			// All pending blocks must be hashed first
			if (host_ready && exp_q.size() != 0) begin
				abort_run("host_ready came before digest_valid of the last block");
			end
		end
	end

	always @(posedge clk) begin
		cycle_cnt++;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			abort_run($sformatf("timeout after %0d cycles, DUT stopped responding", cycle_cnt));
		end
	end

	initial begin
		clk = 1'b0;
		n_rst = 1'b0;
		write_enable = 1'b0;
		rx_data = '0;
		eop = 1'b0;
		rcv_error = 1'b0;
		lcg_state = 32'h6246_9456;
		last_ref = `PD_DIGEST_SEED;
		foreach (pulse_cnt[i]) begin
			pulse_cnt[i] = 0;
			base_cnt[i] = 0;
		end
		repeat (4) @(posedge clk);
		n_rst <= 1'b1;
		repeat (2) @(posedge clk);

		// One good block
		mark_counts();
		make_block(blk_a);
		last_ref = ref_digest(blk_a);
		exp_q.push_back(last_ref);
		send_token(PID_OUT, `PD_DEVICE_ADDR);
		send_data1(blk_a, -1);
		wait_pulse(P_ACK, 1);
		wait_pulse(P_DV, 1);
		settle();
		check_counts(1, 0, 0, 0, 0, 1);

		// Wrong address
		mark_counts();
		make_block(blk_a);
		send_token(PID_OUT, 7'h2A);
		send_data1(blk_a, -1);
		wait_pulse(P_NACK, 1);
		settle();
		check_counts(0, 1, 0, 0, 1, 0);

		// Interrupt command, then an unknown one
		mark_counts();
		send_token(PID_OUT, `PD_DEVICE_ADDR);
		send_data0(CMD_INTERRUPT);
		wait_pulse(P_ACK, 1);
		settle();
		check_counts(1, 0, 0, 1, 0, 0);
		mark_counts();
		send_data0(8'h5A);
		wait_pulse(P_NACK, 1);
		settle();
		check_counts(0, 1, 0, 0, 1, 0);

		// Broken PID complement
		mark_counts();
		send_byte(8'hC4);
		send_byte(8'h00);
		end_packet();
		wait_pulse(P_NACK, 1);
		settle();
		check_counts(0, 1, 0, 0, 1, 0);

		// Receive error inside the payload
		mark_counts();
		make_block(blk_a);
		send_token(PID_OUT, `PD_DEVICE_ADDR);
		send_data1(blk_a, 5);
		wait_pulse(P_NACK, 1);
		settle();
		check_counts(0, 1, 0, 0, 1, 0);
		check_digest(digest, last_ref);

		// IN token while the block is still hashing
		mark_counts();
		make_block(blk_a);
		last_ref = ref_digest(blk_a);
		exp_q.push_back(last_ref);
		send_token(PID_OUT, `PD_DEVICE_ADDR);
		send_data1(blk_a, -1);
		wait_pulse(P_ACK, 1);
		send_token(PID_IN, `PD_DEVICE_ADDR);
		wait_pulse(P_HR, 1);
		settle();
		check_counts(1, 0, 1, 0, 0, 1);

		// Two blocks back to back
		mark_counts();
		make_block(blk_a);
		make_block(blk_b);
		exp_q.push_back(ref_digest(blk_a));
		last_ref = ref_digest(blk_b);
		exp_q.push_back(last_ref);
		send_token(PID_OUT, `PD_DEVICE_ADDR);
		send_data1(blk_a, -1);
		wait_pulse(P_ACK, 1);
		send_data1(blk_b, -1);
		wait_pulse(P_ACK, 2);
		wait_pulse(P_DV, 2);
		settle();
		check_counts(2, 0, 0, 0, 0, 2);
		check_digest(digest, last_ref);

		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

// File: packet_decoder_top.sv
// ============================================================
// Packet decoder top: controller, block store and hasher
// ============================================================
module packet_decoder_top import usb_pkg::*, hash_pkg::*; (
	input logic clk,
	input logic n_rst,
	input logic write_enable,
	input rx_byte_t rx_data,
	input logic eop,
	input logic rcv_error,
	output logic transmit_ack,
	output logic transmit_nack,
	output logic host_ready,
	output logic interrupt,
	output logic p_error,
	output logic digest_valid,
	output digest_t digest
);

	blk_idx_t rd_idx;
	rx_byte_t rd_data;

	block_wr_if blk_if ();
	hash_ctl_if hc_if ();

	pd_controller ctrl_i (
		.clk(clk),
		.n_rst(n_rst),
		.write_enable(write_enable),
		.rx_data(rx_data),
		.eop(eop),
		.rcv_error(rcv_error),
		.blk(blk_if.ctrl),
		.hc(hc_if.ctrl),
		.transmit_ack(transmit_ack),
		.transmit_nack(transmit_nack),
		.host_ready(host_ready),
		.interrupt(interrupt),
		.p_error(p_error)
	);

	block_store store_i (
		.clk(clk),
		.n_rst(n_rst),
		.blk(blk_if.store),
		.rd_idx(rd_idx),
		.rd_data(rd_data)
	);

	block_hasher hasher_i (
		.clk(clk),
		.n_rst(n_rst),
		.hc(hc_if.hasher),
		.rd_data(rd_data),
		.rd_idx(rd_idx),
		.digest(digest)
	);

	// One pulse per completed block
	assign digest_valid = hc_if.done;

endmodule

// File: block_hasher.sv
// ============================================================
// Sequential fold of one stored block into the digest
// ============================================================
`include "pd_params.svh"

module block_hasher import usb_pkg::*, hash_pkg::*; (
	input logic clk,
	input logic n_rst,
	hash_ctl_if.hasher hc,
	input rx_byte_t rd_data,
	output blk_idx_t rd_idx,
	output digest_t digest
);

	typedef enum logic [1:0] {IDLE, RUN, FINISH} state_t;

	localparam blk_idx_t LAST_IDX = blk_idx_t'(`PD_BLOCK_BYTES - 1);

	state_t state;
	blk_idx_t idx;
	digest_t acc;
	digest_t acc_next;
	logic last_byte;

	assign acc_next = fold_byte(acc, rd_data);
	assign last_byte = (state == RUN) && !hc.abort && (idx == LAST_IDX);
	assign rd_idx = idx;
	assign hc.busy = (state != IDLE);
	assign hc.done = (state == FINISH);

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			state <= IDLE;
			idx <= '0;
		end else begin
			case (state)
				IDLE: begin
					if (hc.start) begin
						state <= RUN;
						idx <= '0;
					end
				end
				RUN: begin
					if (hc.abort) begin
						state <= IDLE;
					end else begin
						idx <= idx + 1'b1;
						if (last_byte) begin
							state <= FINISH;
						end
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// Byte 0 first, seed reloaded on every start
	always_ff @(posedge clk) begin
		if (state == IDLE && hc.start) begin
			acc <= `PD_DIGEST_SEED;
		end else if (state == RUN) begin
			acc <= acc_next;
		end
		if (last_byte) begin
			digest <= acc_next;
		end
	end

	a_done_busy: assert property (@(posedge clk) disable iff (!n_rst)
		hc.done |-> (hc.busy && $past(hc.busy, `PD_BLOCK_BYTES)))
		else $error("done without a full busy period");

endmodule

// File: block_store.sv
// ============================================================
// Payload byte counter and block buffer with a read port
// ============================================================
`include "pd_params.svh"

module block_store import usb_pkg::*, hash_pkg::*; (
	input logic clk,
	input logic n_rst,
	block_wr_if.store blk,
	input blk_idx_t rd_idx,
	output rx_byte_t rd_data
);

	localparam blk_cnt_t FULL_CNT = blk_cnt_t'(`PD_BLOCK_BYTES);

	blk_cnt_t count;
	rx_byte_t buffer [`PD_BLOCK_BYTES];
	logic wr_ok;

	// Writes past a full block are dropped
	assign wr_ok = blk.wr_en && !blk.full;
	assign blk.full = (count == FULL_CNT);
	assign rd_data = buffer[rd_idx];

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			count <= '0;
		end else if (blk.clr) begin
			count <= '0;
		end else if (wr_ok) begin
			count <= count + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (wr_ok) begin
			buffer[blk_idx_t'(count)] <= blk.wr_data;
		end
	end

	a_count_max: assert property (@(posedge clk) disable iff (!n_rst)
		count <= FULL_CNT)
		else $error("block count above block size");

endmodule

// File: pd_controller.sv
// ============================================================
// Packet decoder FSM with address check and response pulses
// ============================================================
`include "pd_params.svh"

module pd_controller import usb_pkg::*; (
	input logic clk,
	input logic n_rst,
	input logic write_enable,
	input rx_byte_t rx_data,
	input logic eop,
	input logic rcv_error,
	block_wr_if.ctrl blk,
	hash_ctl_if.ctrl hc,
	output logic transmit_ack,
	output logic transmit_nack,
	output logic host_ready,
	output logic interrupt,
	output logic p_error
);

	typedef enum logic [3:0] {
		IDLE, TOK_ADDR, CMD_BYTE, PAYLOAD, BLOCK_START,
		BLOCK_CLR, ERROR, EOP_HIGH, EOP_LOW, RESPOND
	} state_t;

	// What to send once eop has ended
	typedef enum logic [1:0] {RESP_NONE, RESP_ACK, RESP_NACK, RESP_HOST} resp_t;

	state_t state;
	state_t next_state;
	resp_t resp_q;
	resp_t resp_d;
	logic tok_in_q;
	logic tok_in_d;
	logic valid_addr_q;
	logic valid_addr_d;
	dev_addr_t tok_addr;
	logic addr_match;

	assign tok_addr = rx_data[6:0];
	assign addr_match = (tok_addr == `PD_DEVICE_ADDR);
	assign blk.wr_data = rx_data;

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			state <= IDLE;
			resp_q <= RESP_NONE;
			tok_in_q <= 1'b0;
			valid_addr_q <= 1'b0;
		end else begin
			state <= next_state;
			resp_q <= resp_d;
			tok_in_q <= tok_in_d;
			valid_addr_q <= valid_addr_d;
		end
	end

	always_comb begin
		next_state = state;
		resp_d = resp_q;
		tok_in_d = tok_in_q;
		valid_addr_d = valid_addr_q;
		blk.wr_en = 1'b0;
		blk.clr = 1'b0;
		hc.start = 1'b0;
		hc.abort = 1'b0;
		transmit_ack = 1'b0;
		transmit_nack = 1'b0;
		host_ready = 1'b0;
		interrupt = 1'b0;
		p_error = 1'b0;

		case (state)
			IDLE: begin
				// PID is decoded on its own strobe
				if (write_enable) begin
					resp_d = RESP_NONE;
					if (!pid_ok(rx_data)) begin
						next_state = ERROR;
					end else if (rx_data == PID_IN || rx_data == PID_OUT) begin
						tok_in_d = (rx_data == PID_IN);
						next_state = TOK_ADDR;
					end else if (rx_data == PID_DATA0 && valid_addr_q) begin
						next_state = CMD_BYTE;
					end else if (rx_data == PID_DATA1 && valid_addr_q) begin
						next_state = PAYLOAD;
					end else begin
						next_state = ERROR;
					end
				end
			end
			TOK_ADDR: begin
				if (write_enable) begin
					if (tok_in_q) begin
						resp_d = addr_match ? RESP_HOST : RESP_NONE;
					end else begin
						valid_addr_d = addr_match;
					end
					next_state = EOP_HIGH;
				end
			end
			CMD_BYTE: begin
				if (rcv_error) begin
					next_state = ERROR;
				end else if (write_enable) begin
					if (rx_data == CMD_INTERRUPT) begin
						interrupt = 1'b1;
						resp_d = RESP_ACK;
						next_state = EOP_HIGH;
					end else begin
						next_state = ERROR;
					end
				end
			end
			PAYLOAD: begin
				if (rcv_error) begin
					next_state = ERROR;
				end else if (write_enable) begin
					blk.wr_en = 1'b1;
				end else if (eop) begin
					resp_d = RESP_ACK;
					next_state = blk.full ? BLOCK_START : EOP_LOW;
				end
			end
			BLOCK_START: begin
				if (!hc.busy) begin
					hc.start = 1'b1;
					next_state = BLOCK_CLR;
				end
			end
			BLOCK_CLR: begin
				blk.clr = 1'b1;
				next_state = EOP_LOW;
			end
			ERROR: begin
				// Partial block is dropped along with the hash
				p_error = 1'b1;
				hc.abort = 1'b1;
				blk.clr = 1'b1;
				resp_d = RESP_NACK;
				next_state = EOP_HIGH;
			end
			EOP_HIGH: begin
				if (eop) begin
					next_state = EOP_LOW;
				end
			end
			EOP_LOW: begin
				if (!eop) begin
					next_state = RESPOND;
				end
			end
			RESPOND: begin
				case (resp_q)
					RESP_ACK: begin
						transmit_ack = 1'b1;
						next_state = IDLE;
					end
					RESP_NACK: begin
						transmit_nack = 1'b1;
						next_state = IDLE;
					end
					RESP_HOST: begin
						if (!hc.busy) begin
							host_ready = 1'b1;
							next_state = IDLE;
						end
					end
					default: next_state = IDLE;
				endcase
			end
			default: next_state = IDLE;
		endcase
	end

	a_start_idle: assert property (@(posedge clk) disable iff (!n_rst)
		hc.start |-> (!hc.busy && blk.full))
		else $error("hash start while hasher busy or block not full");

	a_no_wr_idle: assert property (@(posedge clk) disable iff (!n_rst)
		blk.wr_en |-> (state != IDLE && valid_addr_q))
		else $error("block write in idle state or without a valid address");

endmodule

// File: pd_ifs.sv
// ============================================================
// Block write interface and hash control interface
// ============================================================
interface block_wr_if import usb_pkg::*; ();

	logic wr_en;
	logic clr;
	rx_byte_t wr_data;
	logic full;

	modport ctrl (
		output wr_en, clr, wr_data,
		input full
	);

	modport store (
		input wr_en, clr, wr_data,
		output full
	);

endinterface

interface hash_ctl_if ();

	logic start;
	logic abort;
	logic busy;
	logic done;

	modport ctrl (
		output start, abort,
		input busy, done
	);

	modport hasher (
		input start, abort,
		output busy, done
	);

endinterface

// File: hash_pkg.sv
// ============================================================
// Block-side types: byte index, byte count, digest and fold
// ============================================================
`include "pd_params.svh"

package hash_pkg;

	typedef logic [$clog2(`PD_BLOCK_BYTES)-1:0] blk_idx_t;

	// One bit wider than the index so a full block can be counted
	typedef logic [$clog2(`PD_BLOCK_BYTES+1)-1:0] blk_cnt_t;

	typedef logic [31:0] digest_t;

	// Rotate left by 5, then mix in the byte
	function automatic digest_t fold_byte(digest_t d, logic [7:0] b);
		return {d[26:0], d[31:27]} ^ {24'h00_0000, b};
	endfunction

endpackage

// File: usb_pkg.sv
// ============================================================
// Bus-side types, PID codes and command codes
// ============================================================
package usb_pkg;

	typedef logic [7:0] rx_byte_t;
	typedef logic [6:0] dev_addr_t;

	// Token PIDs
	localparam rx_byte_t PID_IN = 8'h69;
	localparam rx_byte_t PID_OUT = 8'hE1;

	// Data PIDs
	localparam rx_byte_t PID_DATA0 = 8'hC3;
	localparam rx_byte_t PID_DATA1 = 8'h4B;

	// DATA0 command bytes
	localparam rx_byte_t CMD_INTERRUPT = 8'h04;
	localparam rx_byte_t CMD_HASH = 8'h01;

	// Upper nibble must be the inverse of the lower one
	function automatic logic pid_ok(rx_byte_t pid);
		return pid[7:4] == ~pid[3:0];
	endfunction

endpackage

// File: pd_params.svh
// ============================================================
// Block size, device address and digest seed macros
// ============================================================
`ifndef PD_PARAMS_SVH
`define PD_PARAMS_SVH

// Payload bytes folded into one digest
`define PD_BLOCK_BYTES 16

// Address this device answers to
`define PD_DEVICE_ADDR 7'h15

// Digest start value, reloaded for every block
`define PD_DIGEST_SEED 32'hA5A5_0F0F

`endif
